// File: bench/fetchTb.sv
`timescale 1ns/1ns
`default_nettype none

module fetchTb;

    localparam logic [31:0] resetPc       = 32'h0;
    localparam logic [31:0] lineMask      = fetchPkg::defaultLineWords * 4 - 1;
    localparam int          timeoutCycles = 6000;  // ~300 fetches at ~20 cycles worst miss

    logic               Clk;
    logic               rst;
    logic               stall;
    logic               redirect;
    logic [31:0]        redirectPc;
    fetchPkg::fetchResp fetchOut;
    logic [31:0]        memReadAddress;
    logic               memReadRequest;
    logic [31:0]        memDataIn;
    logic               memDataReady;

    logic [31:0] lcgState;
    logic [31:0] expPc;           // reference pc model
    int          cycle = 0;
    int          lastOutCycle = 0;
    int          stallOuts = 0;   // fetchOut strobes seen during the current stall
    int          gapLeft;
    logic        sweepHits;       // second sweep, every line resident
    logic        watchLine;       // set conflict phase
    logic        watchNew;
    logic [31:0] watchPc;
    logic        refillSeen = 1'b0;

    fetchTop #(.resetPc(resetPc)) dut (
        .Clk(Clk), .rst(rst), .stall(stall), .redirect(redirect),
        .redirectPc(redirectPc), .fetchOut(fetchOut),
        .memReadAddress(memReadAddress), .memReadRequest(memReadRequest),
        .memDataIn(memDataIn), .memDataReady(memDataReady)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;  // low bits of an LCG repeat too soon
    endfunction

    task automatic endInFailure();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic valueMismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        endInFailure();
    endtask

    task automatic checkFailed(input string why);
        $display("error: %s", why);
        endInFailure();
    endtask

    task automatic stepCycle();
        @(posedge Clk);
        #1;
    endtask

    // returns inside the cycle where fetchOut answers for pc
    task automatic waitForPc(input logic [31:0] pc);
        do begin
            stepCycle();
        end while (!(fetchOut.strobe && fetchOut.addr == pc));
    endtask

    task automatic pulseRedirect(input logic [31:0] target);
        redirect   = 1'b1;
        redirectPc = target;
        stepCycle();
        redirect = 1'b0;
    endtask

    task automatic visitLine(input logic [31:0] target, input logic isNew);
        watchPc  = target;
        watchNew = isNew;
        pulseRedirect(target);
        waitForPc(target);
        stepCycle();  // next word of the same line now in flight
    endtask

    always @(posedge Clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeoutCycles) begin
            $display("error: timeout, no finish after %0d cycles", cycle);
            endInFailure();
        end
    end

    always @(posedge Clk) begin
        if (rst)
            expPc <= resetPc;
        else if (redirect)
            expPc <= redirectPc;
        else if (fetchOut.strobe)
            expPc <= expPc + 32'd4;
        if (fetchOut.strobe)
            lastOutCycle <= cycle;
        if (!stall)
            stallOuts <= 0;
        else if (fetchOut.strobe)
            stallOuts <= stallOuts + 1;
        if (rst || redirect)
            refillSeen <= 1'b0;
        else if (memReadRequest)
            refillSeen <= 1'b1;
    end

    resetQuiet: assert property (@(posedge Clk)
        (cycle > 1) && (rst || $past(rst)) |-> !fetchOut.strobe && !memReadRequest)
        else checkFailed("fetchOut strobe or memReadRequest high around reset");

    pcMatch: assert property (@(posedge Clk) disable iff (rst)
        fetchOut.strobe |-> fetchOut.addr == expPc)
        else valueMismatch("fetchOut.addr", $sampled(expPc), $sampled(fetchOut.addr));

    instMatch: assert property (@(posedge Clk) disable iff (rst)
        fetchOut.strobe |-> fetchOut.inst == ~expPc)
        else valueMismatch("fetchOut.inst", ~$sampled(expPc), $sampled(fetchOut.inst));

    sweepNoRefill: assert property (@(posedge Clk) disable iff (rst)
        sweepHits |-> !memReadRequest)
        else checkFailed("memReadRequest went high while every line was cached");

    hitSpacing: assert property (@(posedge Clk) disable iff (rst)
        sweepHits && fetchOut.strobe |-> cycle - lastOutCycle == 2)
        else valueMismatch("fetchOut.strobe spacing", 32'd2, $sampled(cycle - lastOutCycle));

    stallHold: assert property (@(posedge Clk) disable iff (rst)
        stall && fetchOut.strobe |-> stallOuts == 0)
        else checkFailed("a second fetchOut appeared while stall was high");

    refillAddr: assert property (@(posedge Clk) disable iff (rst)
        watchLine && $rose(memReadRequest) |-> memReadAddress == (watchPc & ~lineMask))
        else valueMismatch("memReadAddress", $sampled(watchPc) & ~lineMask,
                           $sampled(memReadAddress));

    newLineRefill: assert property (@(posedge Clk) disable iff (rst)
        watchLine && watchNew && fetchOut.strobe && fetchOut.addr == watchPc |-> refillSeen)
        else checkFailed("a line fetched for the first time raised no memReadRequest");

    // SDRAM model, one word per pulse after a random gap of 1 to 4 cycles
    initial begin
        lcgState     = 32'h3eec;
        gapLeft      = 1;
        memDataReady = 1'b0;
        memDataIn    = '0;
        forever begin
            stepCycle();
            if (memDataReady || !memReadRequest) begin
                memDataReady = 1'b0;
                gapLeft      = 1 + int'(lcgNext() % 4);
            end else if (gapLeft > 1) begin
                gapLeft--;
            end else begin
                memDataReady = 1'b1;
                memDataIn    = ~memReadAddress;  // word at A is ~A
            end
        end
    end

    initial begin
        rst        = 1'b1;
        stall      = 1'b0;
        redirect   = 1'b0;
        redirectPc = '0;
        sweepHits  = 1'b0;
        watchLine  = 1'b0;
        watchNew   = 1'b0;
        watchPc    = '0;
        repeat (16) @(posedge Clk);
        #1;
        rst = 1'b0;

        // cold sweep of 64 words, then jump back while the 0x100 miss is out
        waitForPc(32'h0fc);
        stepCycle();
        pulseRedirect(32'h0);
        waitForPc(32'h0);
        stepCycle();

        sweepHits = 1'b1;
        waitForPc(32'h0fc);
        stepCycle();
        sweepHits = 1'b0;

        pulseRedirect(32'h040);  // a hit is in flight here
        waitForPc(32'h040);
        stepCycle();

        stall = 1'b1;  // fetch of 0x44 already issued
        repeat (20) stepCycle();
        stall = 1'b0;
        waitForPc(32'h048);
        stepCycle();

        // five lines on set 0, then back among them
        watchLine = 1'b1;
        visitLine(32'h400, 1'b1);
        visitLine(32'h480, 1'b1);
        visitLine(32'h500, 1'b1);
        visitLine(32'h580, 1'b1);
        visitLine(32'h600, 1'b1);
        visitLine(32'h408, 1'b0);
        visitLine(32'h584, 1'b0);
        visitLine(32'h004, 1'b0);
        visitLine(32'h480, 1'b0);
        visitLine(32'h608, 1'b0);
        visitLine(32'h504, 1'b0);
        visitLine(32'h400, 1'b0);
        watchLine = 1'b0;
        repeat (10) stepCycle();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/fetchPkg.sv
logic/fetchSequencer.sv
logic/instCache.sv
logic/sdramBurstReader.sv
logic/fetchTop.sv
bench/fetchTb.sv

// File: logic/fetchPkg.sv
`default_nettype none

package fetchPkg;

    localparam int wordW = 32;           // instruction and address width

    // default cache geometry
    localparam int defaultSets      = 8;
    localparam int defaultWays      = 4;
    localparam int defaultLineWords = 4;

    localparam int maxLineWords = 8;     // sizes the line struct

    // fetch request from the sequencer
    typedef struct packed {
        logic             strobe;
        logic [wordW-1:0] addr;          // byte address
    } fetchReq;

    // response carries the address it answers
    typedef struct packed {
        logic             strobe;
        logic [wordW-1:0] addr;
        logic [wordW-1:0] inst;
    } fetchResp;

    typedef struct packed {
        logic             strobe;
        logic [wordW-1:0] addr;          // line aligned
    } refillReq;

    // only the first lineWords entries carry data
    typedef struct packed {
        logic                                done;
        logic [maxLineWords-1:0][wordW-1:0] words;
    } refillLine;

endpackage

`default_nettype wire

// File: logic/fetchSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module fetchSequencer #(
    parameter logic [fetchPkg::wordW-1:0] resetPc = '0
) (
    input  wire logic                       Clk,
    input  wire logic                       rst,
    input  wire logic                       stall,
    input  wire logic                       redirect,
    input  wire logic [fetchPkg::wordW-1:0] redirectPc,
    output fetchPkg::fetchReq               req,
    input  wire fetchPkg::fetchResp         resp,
    output fetchPkg::fetchResp              fetchOut
);

    logic [fetchPkg::wordW-1:0] pc;
    logic [fetchPkg::wordW-1:0] nextPc;
    logic                       outstanding;  // one fetch in flight
    logic                       squash;       // in-flight fetch is stale
    logic                       reqStrobe;
    logic                       respOk;
    logic                       issue;

    assign respOk = resp.strobe && !squash;

    // free once the pending response shows up
    assign issue = (!outstanding || resp.strobe) && !stall;

    always_comb begin
        if (redirect)
            nextPc = redirectPc;   // redirect wins over the step
        else if (respOk)
            nextPc = pc + fetchPkg::wordW'(4);
        else
            nextPc = pc;
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc          <= resetPc;
            outstanding <= 1'b0;
            squash      <= 1'b0;
            reqStrobe   <= 1'b0;
        end else begin
            pc        <= nextPc;
            reqStrobe <= issue;
            if (issue)
                outstanding <= 1'b1;
            else if (resp.strobe)
                outstanding <= 1'b0;
            // a redirect with a fetch still pending drops that fetch's answer
            if (resp.strobe)
                squash <= 1'b0;
            else if (redirect && outstanding)
                squash <= 1'b1;
        end
    end

    // pc holds the issued address while the strobe is up
    always_comb begin
        req.strobe      = reqStrobe;
        req.addr        = pc;
        fetchOut        = resp;
        fetchOut.strobe = respOk;
    end

endmodule

`default_nettype wire

// File: logic/fetchTop.sv
`timescale 1ns/1ns
`default_nettype none

module fetchTop #(
    parameter int                         numSets   = fetchPkg::defaultSets,
    parameter int                         numWays   = fetchPkg::defaultWays,
    parameter int                         lineWords = fetchPkg::defaultLineWords,
    parameter logic [fetchPkg::wordW-1:0] resetPc   = '0
) (
    input  wire logic                       Clk,
    input  wire logic                       rst,
    input  wire logic                       stall,
    input  wire logic                       redirect,
    input  wire logic [fetchPkg::wordW-1:0] redirectPc,
    output fetchPkg::fetchResp              fetchOut,
    output logic [fetchPkg::wordW-1:0]      memReadAddress,
    output logic                            memReadRequest,
    input  wire logic [fetchPkg::wordW-1:0] memDataIn,
    input  wire logic                       memDataReady
);

    fetchPkg::fetchReq   req;
    fetchPkg::fetchResp  resp;    // raw cache answer, before squash
    fetchPkg::refillReq  refill;
    fetchPkg::refillLine line;

    fetchSequencer #(.resetPc(resetPc)) seq (
        .Clk(Clk), .rst(rst), .stall(stall), .redirect(redirect),
        .redirectPc(redirectPc), .req(req), .resp(resp), .fetchOut(fetchOut)
    );

    instCache #(.numSets(numSets), .numWays(numWays), .lineWords(lineWords)) cache (
        .Clk(Clk), .rst(rst), .req(req), .resp(resp), .refill(refill), .line(line)
    );

    sdramBurstReader #(.lineWords(lineWords)) reader (
        .Clk(Clk), .rst(rst), .refill(refill), .line(line),
        .memReadAddress(memReadAddress), .memReadRequest(memReadRequest),
        .memDataIn(memDataIn), .memDataReady(memDataReady)
    );

endmodule

`default_nettype wire

// File: logic/instCache.sv
`timescale 1ns/1ns
`default_nettype none

module instCache #(
    parameter int numSets   = fetchPkg::defaultSets,
    parameter int numWays   = fetchPkg::defaultWays,
    parameter int lineWords = fetchPkg::defaultLineWords
) (
    input  wire logic                Clk,
    input  wire logic                rst,
    input  wire fetchPkg::fetchReq   req,
    output fetchPkg::fetchResp       resp,
    output fetchPkg::refillReq       refill,
    input  wire fetchPkg::refillLine line
);

    localparam int offW = $clog2(lineWords) + 2;   // byte offset inside a line
    localparam int setW = $clog2(numSets);
    localparam int tagW = fetchPkg::wordW - setW - offW;
    localparam int wayW = $clog2(numWays);

    logic [tagW-1:0]            tagArr   [numSets][numWays];
    logic                       validArr [numSets][numWays];
    logic [fetchPkg::wordW-1:0] dataArr  [numSets][numWays][lineWords];

    // request address fields
    logic [setW-1:0] reqSet;
    logic [tagW-1:0] reqTag;
    logic [offW-3:0] reqWord;

    assign reqSet  = req.addr[offW +: setW];
    assign reqTag  = req.addr[fetchPkg::wordW-1 -: tagW];
    assign reqWord = req.addr[offW-1:2];

    // miss bookkeeping, held until the line lands
    logic [fetchPkg::wordW-1:0] missAddr;
    logic [wayW-1:0]            missWay;
    logic [setW-1:0]            missSet;
    logic [tagW-1:0]            missTag;
    logic [offW-3:0]            missWord;

    assign missSet  = missAddr[offW +: setW];
    assign missTag  = missAddr[fetchPkg::wordW-1 -: tagW];
    assign missWord = missAddr[offW-1:2];

    logic                       waitFill;  // refill outstanding
    logic                       respStrobe;
    logic [fetchPkg::wordW-1:0] respAddr;
    logic [fetchPkg::wordW-1:0] respInst;
    logic                       refillStrobe;
    logic [15:0]                lfsr;

    logic            lookup;
    logic            install;
    logic            hit;
    logic [wayW-1:0] hitWay;
    logic            hasFree;
    logic [wayW-1:0] freeWay;
    logic [wayW-1:0] victimWay;

    assign lookup  = req.strobe && !waitFill;
    assign install = waitFill && line.done;

    // compare every way of the set, walking down so the lowest free way wins
    always_comb begin
        hit     = 1'b0;
        hitWay  = '0;
        hasFree = 1'b0;
        freeWay = '0;
        for (int w = numWays - 1; w >= 0; w--) begin
            if (validArr[reqSet][w] && tagArr[reqSet][w] == reqTag) begin
                hit    = 1'b1;
                hitWay = wayW'(w);
            end
            if (!validArr[reqSet][w]) begin
                hasFree = 1'b1;
                freeWay = wayW'(w);
            end
        end
    end

    // pseudo-random pick only when the set is full; numWays is a power of two
    assign victimWay = hasFree ? freeWay : lfsr[wayW-1:0];

    always_ff @(posedge Clk) begin
        if (rst) begin
            respStrobe   <= 1'b0;
            refillStrobe <= 1'b0;
            waitFill     <= 1'b0;
            lfsr         <= 16'hace1;
            for (int s = 0; s < numSets; s++) begin
                for (int w = 0; w < numWays; w++) begin
                    validArr[s][w] <= 1'b0;
                end
            end
        end else begin
            lfsr         <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            respStrobe   <= (lookup && hit) || install;
            refillStrobe <= lookup && !hit;
            if (lookup && !hit) begin
                waitFill <= 1'b1;
            end else if (install) begin
                waitFill                   <= 1'b0;
                validArr[missSet][missWay] <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (lookup) begin
            respAddr <= req.addr;
            respInst <= dataArr[reqSet][hitWay][reqWord];  // only used on a hit
            if (!hit) begin
                missAddr <= req.addr;
                missWay  <= victimWay;
            end
        end
        if (install) begin
            for (int k = 0; k < lineWords; k++) begin
                dataArr[missSet][missWay][k] <= line.words[k];
            end
            tagArr[missSet][missWay] <= missTag;
            respAddr                 <= missAddr;
            respInst                 <= line.words[missWord];  // answer straight from the line
        end
    end

    always_comb begin
        resp.strobe   = respStrobe;
        resp.addr     = respAddr;
        resp.inst     = respInst;
        refill.strobe = refillStrobe;
        refill.addr   = {missAddr[fetchPkg::wordW-1:offW], {offW{1'b0}}};
    end

endmodule

`default_nettype wire

// File: logic/sdramBurstReader.sv
`timescale 1ns/1ns
`default_nettype none

module sdramBurstReader #(
    parameter int lineWords = fetchPkg::defaultLineWords
) (
    input  wire logic                       Clk,
    input  wire logic                       rst,
    input  wire fetchPkg::refillReq         refill,
    output fetchPkg::refillLine             line,
    output logic [fetchPkg::wordW-1:0]      memReadAddress,
    output logic                            memReadRequest,
    input  wire logic [fetchPkg::wordW-1:0] memDataIn,
    input  wire logic                       memDataReady
);

    localparam int cntW = (lineWords > 1) ? $clog2(lineWords) : 1;

    logic [cntW-1:0]                            wordCnt;
    logic [lineWords-1:0][fetchPkg::wordW-1:0] lineBuf;  // line being assembled
    logic                                       lineDone;
    logic                                       start;
    logic                                       take;
    logic                                       lastWord;

    assign start    = refill.strobe && !memReadRequest;
    assign take     = memReadRequest && memDataReady;
    assign lastWord = wordCnt == cntW'(lineWords - 1);

    always_ff @(posedge Clk) begin
        if (rst) begin
            memReadRequest <= 1'b0;
            lineDone       <= 1'b0;
            wordCnt        <= '0;
        end else begin
            lineDone <= take && lastWord;
            if (start) begin
                memReadRequest <= 1'b1;
                wordCnt        <= '0;
            end else if (take) begin
                if (lastWord)
                    memReadRequest <= 1'b0;  // drops together with the line strobe
                else
                    wordCnt <= wordCnt + 1'b1;
            end
        end
    end

    // byte address of the word being read, ascending from the line start
    always_ff @(posedge Clk) begin
        if (start) begin
            memReadAddress <= refill.addr;
        end else if (take) begin
            lineBuf[wordCnt] <= memDataIn;
            memReadAddress   <= memReadAddress + fetchPkg::wordW'(4);
        end
    end

    always_comb begin
        line.done  = lineDone;
        line.words = '0;
        for (int k = 0; k < lineWords; k++) begin
            line.words[k] = lineBuf[k];
        end
    end

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fetchTb \
    -f flist.f -o fetchSim || { echo "build failed"; exit 1; }
simOut=$(./obj_dir/fetchSim)
echo "$simOut"
echo "$simOut" | grep -qF '** PASS **' && exit 0 || exit 1
